// ==== src/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

  // Access size of a load or store.
  typedef enum logic [1:0] {
    OP_LS_WORD     = 2'd0,
    OP_LS_HALFWORD = 2'd1,
    OP_LS_BYTE     = 2'd2
  } ls_op_t;

  // One operation presented to the data-memory stage.
  typedef struct packed {
    logic        load;
    logic        store;
    ls_op_t      ls_op;
    logic        sext;        // Sign extend sub-word loads.
    logic [31:0] addr;        // AGU address.
    logic [31:0] store_data;
  } mem_req_t;

  // Stage to data RAM.
  typedef struct packed {
    logic        rd;
    logic        wr;
    logic [31:0] addr;
    logic [31:0] wr_data;
    logic [3:0]  wr_be;       // Bit 3 is lane 0, bits 31:24.
  } cache_req_t;

  // Stage to trickbox.
  typedef struct packed {
    logic        read;
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
  } tb_req_t;

  // Trickbox window is 4 KB.
  localparam int TB_WINDOW_BITS = 12;

  // Register offsets inside the window.
  localparam logic [TB_WINDOW_BITS-1:0] TB_OFS_SCRATCH = 12'h000;
  localparam logic [TB_WINDOW_BITS-1:0] TB_OFS_STORES  = 12'h004;
  localparam logic [TB_WINDOW_BITS-1:0] TB_OFS_CHAR    = 12'h008;

endpackage

`default_nettype wire

// ==== src/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  wire                   clock,
  input  wire                   reset_n,

  input  mem_pkg::mem_req_t     req,

  output mem_pkg::cache_req_t   cache_req,
  input  wire [31:0]            cache_rdata,
  input  wire                   cache_waitrequest,

  output mem_pkg::tb_req_t      tb_req,
  input  wire                   tb_taken,
  input  wire [31:0]            tb_rdata,

  output logic [31:0]           result,
  output logic                  stall
);

  logic [1:0]  word_idx;
  logic [31:0] byte_shifted;
  logic [31:0] half_shifted;
  logic [31:0] load_word;
  logic [31:0] store_word;
  logic [3:0]  store_be;
  logic        stall_q;

  assign word_idx = req.addr[1:0];

  // Only the RAM can hold the pipeline.
  assign stall = cache_waitrequest;

  // Trickbox sees whole words regardless of size.
  assign tb_req.read  = req.load;
  assign tb_req.write = req.store;
  assign tb_req.addr  = req.addr;
  assign tb_req.data  = req.store_data;

  // Claimed accesses never reach the RAM.
  assign cache_req.rd      = req.load && !tb_taken;
  assign cache_req.wr      = req.store && !tb_taken;
  assign cache_req.addr    = req.addr;
  assign cache_req.wr_data = store_word;
  assign cache_req.wr_be   = store_be;

  // Lane 0 is the most significant byte.
  assign byte_shifted = cache_rdata >> {~word_idx, 3'b000};
  assign half_shifted = cache_rdata >> {~word_idx[1], 4'b0000};

  always_comb begin
    case (req.ls_op)
      mem_pkg::OP_LS_BYTE: begin
        load_word = {{24{req.sext && byte_shifted[7]}}, byte_shifted[7:0]};
      end
      mem_pkg::OP_LS_HALFWORD: begin
        load_word = {{16{req.sext && half_shifted[15]}}, half_shifted[15:0]};
      end
      default: begin
        load_word = cache_rdata;
      end
    endcase
  end

  // Replicate, then let the enables pick the lanes.
  always_comb begin
    case (req.ls_op)
      mem_pkg::OP_LS_BYTE: begin
        store_word = {4{req.store_data[7:0]}};
        store_be   = 4'b1000 >> word_idx;
      end
      mem_pkg::OP_LS_HALFWORD: begin
        store_word = {2{req.store_data[15:0]}};
        store_be   = word_idx[1] ? 4'b0011 : 4'b1100;
      end
      default: begin
        store_word = req.store_data;
        store_be   = 4'b1111;
      end
    endcase
  end

  always_comb begin
    if (tb_taken) begin
      result = tb_rdata;
    end else if (req.load) begin
      result = load_word;
    end else begin
      result = req.addr; // Non-memory ops pass the address.
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= stall;
    end
  end

  a_half_aligned: assert property (
    @(posedge clock) disable iff (!reset_n)
    ((req.load || req.store) && req.ls_op == mem_pkg::OP_LS_HALFWORD) |-> !req.addr[0]
  ) else $error("halfword access at odd lane index");

  a_one_kind: assert property (
    @(posedge clock) disable iff (!reset_n)
    !(req.load && req.store)
  ) else $error("load and store high together");

  // Producer must hold the operation across a RAM wait.
  a_req_held: assert property (
    @(posedge clock) disable iff (!reset_n)
    stall_q |-> (req == $past(req))
  ) else $error("request changed while stalled");

endmodule

`default_nettype wire

// ==== src/trickbox.sv ====
`timescale 1ns/1ps
`default_nettype none

module trickbox #(
  parameter int                    ADDR_WIDTH = 32,
  parameter logic [ADDR_WIDTH-1:0] TB_BASE    = 32'hFFFF_F000
) (
  input  wire                clock,
  input  wire                reset_n,

  input  mem_pkg::tb_req_t   tb_req,
  output logic               taken,
  output logic [31:0]        rdata,

  output logic [7:0]         char_out,
  output logic               char_valid
);

  localparam int WIN = mem_pkg::TB_WINDOW_BITS;

  logic           hit;
  logic [WIN-1:0] ofs;
  logic           wr_en;
  logic [31:0]    scratch;
  logic [31:0]    store_cnt;
  logic [7:0]     char_q;

  assign hit = (tb_req.addr[ADDR_WIDTH-1:WIN] == TB_BASE[ADDR_WIDTH-1:WIN]);

  // Word offset, byte bits dropped.
  assign ofs = {tb_req.addr[WIN-1:2], 2'b00};

  assign taken = hit && (tb_req.read || tb_req.write);
  assign wr_en = taken && tb_req.write;

  always_comb begin
    case (ofs)
      mem_pkg::TB_OFS_SCRATCH: begin
        rdata = scratch;
      end
      mem_pkg::TB_OFS_STORES: begin
        rdata = store_cnt;
      end
      mem_pkg::TB_OFS_CHAR: begin
        rdata = {24'h0, char_q};
      end
      default: begin
        rdata = 32'h0;
      end
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      scratch    <= 32'h0;
      store_cnt  <= 32'h0;
      char_q     <= 8'h0;
      char_valid <= 1'b0;
    end else begin
      char_valid <= 1'b0;
      if (wr_en) begin
        store_cnt <= store_cnt + 32'd1; // Any window write, wraps.
        if (ofs == mem_pkg::TB_OFS_SCRATCH) begin
          scratch <= tb_req.data;
        end
        if (ofs == mem_pkg::TB_OFS_CHAR) begin
          char_q     <= tb_req.data[7:0];
          char_valid <= 1'b1;
        end
      end
    end
  end

  assign char_out = char_q;

endmodule

`default_nettype wire

// ==== src/data_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
  parameter int ADDR_WIDTH = 32,
  parameter int RAM_WORDS  = 256
) (
  input  wire                  clock,
  input  wire                  reset_n,

  input  mem_pkg::cache_req_t  cache_req,
  output logic [31:0]          rdata,
  output logic                 waitrequest
);

  localparam int IDX_W = $clog2(RAM_WORDS);

  typedef enum logic {
    S_IDLE,
    S_WAIT
  } state_t;

  logic [31:0]           mem [RAM_WORDS];
  logic [ADDR_WIDTH-3:0] word_addr;
  logic [IDX_W-1:0]      idx;
  logic                  access;
  logic                  done;
  logic [1:0]            draw;
  logic [7:0]            lfsr;
  logic                  lfsr_step;
  state_t                state;
  state_t                next_state;
  logic [1:0]            cnt;
  logic [1:0]            next_cnt;

  assign word_addr = cache_req.addr[ADDR_WIDTH-1:2];
  assign idx       = word_addr[IDX_W-1:0]; // Depth is a power of two.

  assign access    = cache_req.rd || cache_req.wr;
  assign draw      = lfsr[1:0];
  assign lfsr_step = (state == S_IDLE) && access;

  always_comb begin
    next_state  = state;
    next_cnt    = cnt;
    waitrequest = 1'b0;
    case (state)
      S_IDLE: begin
        if (access && draw != 2'd0) begin
          waitrequest = 1'b1;
          next_state  = S_WAIT;
          next_cnt    = draw - 2'd1;
        end
      end
      S_WAIT: begin
        if (!access) begin
          next_state = S_IDLE; // Request withdrawn.
        end else if (cnt != 2'd0) begin
          waitrequest = 1'b1;
          next_cnt    = cnt - 2'd1;
        end else begin
          next_state = S_IDLE;
        end
      end
      default: begin
        next_state = S_IDLE;
      end
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= S_IDLE;
      cnt   <= 2'd0;
      lfsr  <= 8'hA5;
    end else begin
      state <= next_state;
      cnt   <= next_cnt;
      if (lfsr_step) begin
        lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
      end
    end
  end

  assign done = access && !waitrequest;

  always_ff @(posedge clock) begin
    if (done && cache_req.wr) begin
      for (int j = 0; j < 4; j++) begin
        if (cache_req.wr_be[j]) begin
          mem[idx][8*j +: 8] <= cache_req.wr_data[8*j +: 8];
        end
      end
    end
  end

  assign rdata = mem[idx];

  a_rd_wr_excl: assert property (
    @(posedge clock) disable iff (!reset_n)
    !(cache_req.rd && cache_req.wr)
  ) else $error("RAM read and write requested together");

endmodule

`default_nettype wire

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem #(
  parameter int                    ADDR_WIDTH = 32,
  parameter int                    RAM_WORDS  = 256,
  parameter logic [ADDR_WIDTH-1:0] TB_BASE    = 32'hFFFF_F000
) (
  input  wire                 clock,
  input  wire                 reset_n,

  input  mem_pkg::mem_req_t   req,
  output logic [31:0]         result,
  output logic                stall,

  output logic [7:0]          char_out,
  output logic                char_valid
);

  mem_pkg::cache_req_t cache_req;
  logic [31:0]         cache_rdata;
  logic                cache_waitrequest;
  mem_pkg::tb_req_t    tb_req;
  logic                tb_taken;
  logic [31:0]         tb_rdata;

  mem_stage u_stage (
    .clock             (clock),
    .reset_n           (reset_n),
    .req               (req),
    .cache_req         (cache_req),
    .cache_rdata       (cache_rdata),
    .cache_waitrequest (cache_waitrequest),
    .tb_req            (tb_req),
    .tb_taken          (tb_taken),
    .tb_rdata          (tb_rdata),
    .result            (result),
    .stall             (stall)
  );

  trickbox #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .TB_BASE    (TB_BASE)
  ) u_trickbox (
    .clock      (clock),
    .reset_n    (reset_n),
    .tb_req     (tb_req),
    .taken      (tb_taken),
    .rdata      (tb_rdata),
    .char_out   (char_out),
    .char_valid (char_valid)
  );

  data_ram #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .RAM_WORDS  (RAM_WORDS)
  ) u_ram (
    .clock       (clock),
    .reset_n     (reset_n),
    .cache_req   (cache_req),
    .rdata       (cache_rdata),
    .waitrequest (cache_waitrequest)
  );

endmodule

`default_nettype wire

// ==== sim/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Expected RAM contents keyed by word index, and trickbox registers.
logic [31:0] model_mem [int];
logic [31:0] model_scratch;
logic [31:0] model_stores;
logic [7:0]  model_char;
logic [31:0] rng_state;

function automatic logic [31:0] next_random();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

function automatic logic in_window(input logic [31:0] addr);
  return addr[31:12] == TB_BASE[31:12];
endfunction

function automatic int ram_index(input logic [31:0] addr);
  return int'((addr >> 2) % RAM_WORDS);
endfunction

// Lane 0 sits in bits 31:24.
function automatic logic [31:0] extract_lanes(input logic [31:0] word, input logic [1:0] lane,
    input mem_pkg::ls_op_t op, input logic sext);
  logic [7:0]  b;
  logic [15:0] h;
  b = word[31 - 8*lane -: 8];
  h = word[31 - 16*lane[1] -: 16];
  case (op)
    mem_pkg::OP_LS_BYTE:     return sext ? {{24{b[7]}}, b} : {24'h0, b};
    mem_pkg::OP_LS_HALFWORD: return sext ? {{16{h[15]}}, h} : {16'h0, h};
    default:                 return word;
  endcase
endfunction

function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] data,
    input logic [1:0] lane, input mem_pkg::ls_op_t op);
  logic [31:0] w;
  w = old;
  case (op)
    mem_pkg::OP_LS_BYTE:     w[31 - 8*lane -: 8] = data[7:0];
    mem_pkg::OP_LS_HALFWORD: w[31 - 16*lane[1] -: 16] = data[15:0];
    default:                 w = data;
  endcase
  return w;
endfunction

function automatic logic [31:0] trickbox_read(input logic [31:0] addr);
  case ({addr[11:2], 2'b00})
    mem_pkg::TB_OFS_SCRATCH: return model_scratch;
    mem_pkg::TB_OFS_STORES:  return model_stores;
    mem_pkg::TB_OFS_CHAR:    return {24'h0, model_char};
    default:                 return 32'h0;
  endcase
endfunction

// Returns the expected result, then applies the side effects.
function automatic logic [31:0] apply_model(input mem_pkg::mem_req_t r);
  logic [31:0] exp;
  logic [31:0] old;
  int          idx;
  idx = ram_index(r.addr);
  old = model_mem.exists(idx) ? model_mem[idx] : 32'hx;
  if ((r.load || r.store) && in_window(r.addr)) begin
    exp = trickbox_read(r.addr); // Read before write.
    if (r.store) begin
      model_stores = model_stores + 32'd1;
      if ({r.addr[11:2], 2'b00} == mem_pkg::TB_OFS_SCRATCH) begin
        model_scratch = r.store_data;
      end
      if ({r.addr[11:2], 2'b00} == mem_pkg::TB_OFS_CHAR) begin
        model_char = r.store_data[7:0];
      end
    end
  end else if (r.load) begin
    exp = extract_lanes(old, r.addr[1:0], r.ls_op, r.sext);
  end else begin
    exp = r.addr;
    if (r.store) begin
      model_mem[idx] = merge_lanes(old, r.store_data, r.addr[1:0], r.ls_op);
    end
  end
  return exp;
endfunction

`endif

// ==== sim/tb_mem_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;

  localparam int          ADDR_WIDTH = 32;
  localparam int          RAM_WORDS  = 256;
  localparam logic [31:0] TB_BASE    = 32'hFFFF_F000;
  localparam int          MAX_WAIT   = 50;

  logic              clock;
  logic              reset_n;
  mem_pkg::mem_req_t req;
  logic [31:0]       result;
  logic              stall;
  logic [7:0]        char_out;
  logic              char_valid;

  int   err_count;
  int   check_count;
  int   tests_run;
  int   tests_failed;
  int   test_err_base;
  int   stall_total;
  logic last_stalled;

  `include "tb_model.svh"

  mem_subsystem #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .RAM_WORDS  (RAM_WORDS),
    .TB_BASE    (TB_BASE)
  ) u_dut (
    .clock      (clock),
    .reset_n    (reset_n),
    .req        (req),
    .result     (result),
    .stall      (stall),
    .char_out   (char_out),
    .char_valid (char_valid)
  );

  always #4 clock = ~clock;

  task automatic check_result(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_char(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got 0x%02h, expected 0x%02h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (err_count != test_err_base) begin
      tests_failed++;
    end
    $display("test %-16s %s, %0d errors", name,
             (err_count == test_err_base) ? "ok" : "FAILED", err_count - test_err_base);
    test_err_base = err_count;
  endtask

  function automatic mem_pkg::ls_op_t pick_size(input logic [1:0] sel);
    case (sel)
      2'd0:    return mem_pkg::OP_LS_WORD;
      2'd1:    return mem_pkg::OP_LS_HALFWORD;
      default: return mem_pkg::OP_LS_BYTE;
    endcase
  endfunction

  function automatic mem_pkg::mem_req_t make_req(input logic load, input logic store,
      input mem_pkg::ls_op_t op, input logic sext, input logic [31:0] addr,
      input logic [31:0] data);
    return '{load, store, op, sext, addr, data};
  endfunction

  // Outside the trickbox window, aligned to the access size.
  function automatic logic [31:0] random_ram_addr(input mem_pkg::ls_op_t op);
    logic [31:0] a;
    a = next_random();
    a[31] = 1'b0;
    a[1:0] = (op == mem_pkg::OP_LS_WORD) ? 2'b00 :
             (op == mem_pkg::OP_LS_HALFWORD) ? {a[1], 1'b0} : a[1:0];
    return a;
  endfunction

  function automatic mem_pkg::mem_req_t random_req();
    logic [31:0]     pick;
    mem_pkg::ls_op_t op;
    logic [31:0]     addr;
    pick = next_random();
    op   = pick_size(pick[5:4]);
    addr = random_ram_addr(op);
    if (pick[2:0] == 3'd0) begin
      return make_req(1'b0, 1'b0, op, pick[6], next_random(), next_random());
    end
    if (pick[2:0] <= 3'd2) begin
      addr = TB_BASE | {pick[9:8], 2'b00}; // Scratch, stores, char or unmapped.
    end
    return make_req(pick[3], !pick[3], op, pick[6], addr, next_random());
  endfunction

  task automatic issue_op(input mem_pkg::mem_req_t r, output logic [31:0] got);
    int   waits;
    logic done;
    waits = 0;
    done  = 1'b0;
    got   = 32'hx;
    @(posedge clock);
    req <= r;
    while (!done && waits < MAX_WAIT) begin
      @(negedge clock);
      if (stall) begin
        waits++;
      end else begin
        got  = result;
        done = 1'b1;
      end
    end
    @(posedge clock); // Accepting edge.
    req <= '0;
    last_stalled = (waits != 0);
    stall_total += waits;
    if (!done) begin
      err_count++;
      $display("timeout: operation at 0x%08h not accepted within %0d cycles", r.addr, MAX_WAIT);
    end
  endtask

  task automatic run_op(input mem_pkg::mem_req_t r);
    logic [31:0] exp;
    logic [31:0] got;
    exp = apply_model(r);
    issue_op(r, got);
    check_result($sformatf("result @ 0x%08h", r.addr), got, exp);
  endtask

  initial begin
    mem_pkg::mem_req_t r;
    logic [31:0]       base;
    logic              seen;
    clock         = 1'b0;
    reset_n       = 1'b0;
    req           = '0;
    err_count     = 0;
    check_count   = 0;
    tests_run     = 0;
    tests_failed  = 0;
    test_err_base = 0;
    stall_total   = 0;
    last_stalled  = 1'b0;
    rng_state     = 32'h45c4;
    model_scratch = 32'h0;
    model_stores  = 32'h0;
    model_char    = 8'h0;

    repeat (8) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    check_flag("stall", stall, 1'b0);
    check_flag("char_valid", char_valid, 1'b0);
    finish_test("reset_state");

    // Every word gets written here, so later loads never see an unwritten word.
    for (int i = 0; i < RAM_WORDS; i++) begin
      base = random_ram_addr(mem_pkg::OP_LS_WORD);
      run_op(make_req(1'b0, 1'b1, mem_pkg::OP_LS_WORD, 1'b0,
                      {base[31:10], i[7:0], 2'b00}, next_random()));
    end
    for (int i = 0; i < RAM_WORDS; i++) begin
      base = random_ram_addr(mem_pkg::OP_LS_WORD);
      run_op(make_req(1'b1, 1'b0, mem_pkg::OP_LS_WORD, 1'b0,
                      {base[31:10], i[7:0], 2'b00}, 32'h0));
    end
    finish_test("word_round_trip");

    for (int n = 0; n < 16; n++) begin
      base = random_ram_addr(mem_pkg::OP_LS_WORD);
      for (int k = 0; k < 8; k++) begin
        run_op(make_req(1'b1, 1'b0, mem_pkg::OP_LS_BYTE, k[0], base | k[2:1], 32'h0));
      end
      for (int k = 0; k < 4; k++) begin
        run_op(make_req(1'b1, 1'b0, mem_pkg::OP_LS_HALFWORD, k[0],
                        base | {k[1], 1'b0}, 32'h0));
      end
    end
    finish_test("subword_loads");

    for (int n = 0; n < 32; n++) begin
      r = make_req(1'b0, 1'b1, pick_size(n[0] ? 2'd2 : 2'd1), 1'b0, 32'h0, next_random());
      r.addr = random_ram_addr(r.ls_op);
      run_op(r);
      run_op(make_req(1'b1, 1'b0, mem_pkg::OP_LS_WORD, 1'b0, {r.addr[31:2], 2'b00}, 32'h0));
    end
    finish_test("subword_stores");

    run_op(make_req(1'b0, 1'b1, mem_pkg::OP_LS_WORD, 1'b0,
                    TB_BASE | mem_pkg::TB_OFS_SCRATCH, next_random()));
    run_op(make_req(1'b1, 1'b0, mem_pkg::OP_LS_WORD, 1'b0,
                    TB_BASE | mem_pkg::TB_OFS_SCRATCH, 32'h0));
    run_op(make_req(1'b1, 1'b0, mem_pkg::OP_LS_WORD, 1'b0,
                    TB_BASE | mem_pkg::TB_OFS_STORES, 32'h0));
    run_op(make_req(1'b0, 1'b1, mem_pkg::OP_LS_BYTE, 1'b0,
                    TB_BASE | mem_pkg::TB_OFS_CHAR, next_random()));
    seen = 1'b0;
    for (int k = 0; k < 2 && !seen; k++) begin
      @(negedge clock);
      seen = char_valid;
    end
    if (!seen) begin
      err_count++;
      $display("char_valid did not pulse within two cycles of the character write");
    end else begin
      check_char("char_out", char_out, model_char);
    end
    run_op(make_req(1'b1, 1'b0, mem_pkg::OP_LS_WORD, 1'b0,
                    TB_BASE | mem_pkg::TB_OFS_CHAR, 32'h0));
    finish_test("trickbox_regs");

    for (int n = 0; n < 16; n++) begin
      run_op(make_req(1'b0, 1'b0, pick_size(n[1:0]), n[2], next_random(), next_random()));
      check_flag("stall", last_stalled, 1'b0);
    end
    // Low ten address bits of a window register pick the same RAM word.
    for (int k = 0; k < 3; k++) begin
      base = (TB_BASE + 4 * k) & 32'h0000_03FF;
      run_op(make_req(1'b0, 1'b1, mem_pkg::OP_LS_WORD, 1'b0, base, next_random()));
      run_op(make_req(1'b0, 1'b1, mem_pkg::OP_LS_WORD, 1'b0, TB_BASE + 4 * k, next_random()));
      check_flag("stall", last_stalled, 1'b0);
      run_op(make_req(1'b1, 1'b0, mem_pkg::OP_LS_WORD, 1'b0, base, 32'h0));
    end
    finish_test("passthru_isolate");

    repeat (300) run_op(random_req());
    finish_test("back_pressure");

    $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d; stall cycles: %0d",
             tests_run, tests_failed, check_count, err_count, stall_total);
    if (err_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+sim
src/mem_pkg.sv
src/mem_stage.sv
src/trickbox.sv
src/data_ram.sv
src/mem_subsystem.sv
sim/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - src/mem_pkg.sv
  - src/mem_stage.sv
  - src/trickbox.sv
  - src/data_ram.sv
  - src/mem_subsystem.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_mem_subsystem.sv
